/* hw/vdp_pkg.sv */
package vdp_pkg;

  localparam int data_width     = 64;
  localparam int spm_words      = 32;
  localparam int spm_addr_width = 5;
  localparam int max_len        = 8;

  // Register indices, low 3 bits of the command address.
  localparam logic [2:0] reg_a_ptr   = 3'd0;
  localparam logic [2:0] reg_b_ptr   = 3'd1;
  localparam logic [2:0] reg_len     = 3'd2;
  localparam logic [2:0] reg_start   = 3'd3;
  localparam logic [2:0] reg_status  = 3'd4;
  localparam logic [2:0] reg_res_ptr = 3'd5;

  localparam int status_done_bit = 0; // Sticky, cleared by start.
  localparam int status_busy_bit = 1;

  typedef logic [data_width-1:0]     data_t;
  typedef logic [spm_addr_width-1:0] spm_addr_t;
  typedef logic [3:0]                vec_len_t;  // Holds 1..max_len.

  typedef enum logic [2:0] {
    e_idle,
    e_fetch_a,
    e_wait_a,
    e_fetch_b,
    e_wait_b,
    e_write,
    e_done
  } engine_state_e;

endpackage

/* hw/vdp_csr_file.sv */
`timescale 1ns/10ps

module vdp_csr_file (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               cmd_v_i,
  input  logic               cmd_we_i,
  input  logic               cmd_spm_i,
  input  vdp_pkg::spm_addr_t cmd_addr_i,
  input  vdp_pkg::data_t     cmd_wdata_i,
  output logic               resp_v_o,
  output vdp_pkg::data_t     resp_rdata_o,
  output logic               host_req_o,
  output logic               host_we_o,
  output vdp_pkg::spm_addr_t host_addr_o,
  output vdp_pkg::data_t     host_wdata_o,
  input  logic               host_rvalid_i,
  input  vdp_pkg::data_t     rdata_i,
  output logic               start_o,
  output vdp_pkg::spm_addr_t a_ptr_o,
  output vdp_pkg::spm_addr_t b_ptr_o,
  output vdp_pkg::spm_addr_t res_ptr_o,
  output vdp_pkg::vec_len_t  len_o,
  input  logic               busy_i,
  input  logic               done_i
);
  import vdp_pkg::*;

  logic [2:0] reg_idx;
  logic       reg_wr;
  logic       start_n;
  logic       done_r;
  logic       resp_v_r;
  data_t      resp_data_r;
  data_t      rd_data;
  vec_len_t   len_clamped;

  assign reg_idx = cmd_addr_i[2:0];
  assign reg_wr  = cmd_v_i && cmd_we_i && !cmd_spm_i;
  assign start_n = reg_wr && (reg_idx == reg_start) && (cmd_wdata_i != '0) && !busy_i;

  always_comb begin
    if (cmd_wdata_i == '0)
      len_clamped = vec_len_t'(1);
    else if (cmd_wdata_i > data_t'(max_len))
      len_clamped = vec_len_t'(max_len);
    else
      len_clamped = vec_len_t'(cmd_wdata_i);
  end

  always_comb begin
    rd_data = '0;
    case (reg_idx)
      reg_a_ptr:   rd_data = data_t'(a_ptr_o);
      reg_b_ptr:   rd_data = data_t'(b_ptr_o);
      reg_len:     rd_data = data_t'(len_o);
      reg_res_ptr: rd_data = data_t'(res_ptr_o);
      reg_status: begin
        rd_data[status_done_bit] = done_r;
        rd_data[status_busy_bit] = busy_i;
      end
      default:     rd_data = '0; // Start is write-only.
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_o    <= '0;
      b_ptr_o    <= '0;
      res_ptr_o  <= '0;
      len_o      <= vec_len_t'(1);
      start_o    <= 1'b0;
      done_r     <= 1'b0;
      resp_v_r   <= 1'b0;
      host_req_o <= 1'b0;
    end else begin
      if (reg_wr && reg_idx == reg_a_ptr) a_ptr_o <= spm_addr_t'(cmd_wdata_i);
      if (reg_wr && reg_idx == reg_b_ptr) b_ptr_o <= spm_addr_t'(cmd_wdata_i);
      if (reg_wr && reg_idx == reg_res_ptr) res_ptr_o <= spm_addr_t'(cmd_wdata_i);
      if (reg_wr && reg_idx == reg_len) len_o <= len_clamped;
      start_o <= start_n;
      if (start_o)
        done_r <= 1'b0;
      else if (done_i)
        done_r <= 1'b1;
      resp_v_r   <= cmd_v_i && !(cmd_spm_i && !cmd_we_i); // SPM reads answer later.
      host_req_o <= cmd_v_i && cmd_spm_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      resp_data_r  <= (cmd_we_i || cmd_spm_i) ? '0 : rd_data;
      host_we_o    <= cmd_we_i;
      host_addr_o  <= cmd_addr_i;
      host_wdata_o <= cmd_wdata_i;
    end
  end

  assign resp_v_o     = resp_v_r || host_rvalid_i;
  assign resp_rdata_o = host_rvalid_i ? rdata_i : resp_data_r;

  // Host must wait for the read response before its next command.
  a_no_cmd_during_read: assert property (@(posedge clk_i) disable iff (reset_i)
    (host_req_o && !host_we_o) |-> !cmd_v_i);

endmodule

/* hw/vdp_engine.sv */
`timescale 1ns/10ps

module vdp_engine (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               start_i,
  input  vdp_pkg::spm_addr_t a_ptr_i,
  input  vdp_pkg::spm_addr_t b_ptr_i,
  input  vdp_pkg::spm_addr_t res_ptr_i,
  input  vdp_pkg::vec_len_t  len_i,
  output logic               busy_o,
  output logic               done_o,
  output logic               eng_req_o,
  output logic               eng_we_o,
  output vdp_pkg::spm_addr_t eng_addr_o,
  output vdp_pkg::data_t     eng_wdata_o,
  input  logic               eng_gnt_i,
  input  logic               eng_rvalid_i,
  input  vdp_pkg::data_t     rdata_i
);
  import vdp_pkg::*;

  engine_state_e state_r, state_n;

  spm_addr_t a_ptr_r;
  spm_addr_t b_ptr_r;
  spm_addr_t res_ptr_r;
  vec_len_t  len_r;
  logic [$clog2(max_len)-1:0] idx_r;
  logic      last_lane;

  data_t vec_a [max_len];
  data_t vec_b [max_len];
  data_t prod [max_len];
  data_t sum_l1 [max_len/2];
  data_t sum_l2 [max_len/4];

  assign last_lane = (vec_len_t'(idx_r) == len_r - vec_len_t'(1));

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle:    if (start_i) state_n = e_fetch_a;
      e_fetch_a: if (eng_gnt_i) state_n = e_wait_a;
      e_wait_a:  if (eng_rvalid_i) state_n = last_lane ? e_fetch_b : e_fetch_a;
      e_fetch_b: if (eng_gnt_i) state_n = e_wait_b;
      e_wait_b:  if (eng_rvalid_i) state_n = last_lane ? e_write : e_fetch_b;
      e_write:   if (eng_gnt_i) state_n = e_done;
      e_done:    state_n = e_idle;
      default:   state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      idx_r   <= '0;
    end else begin
      state_r <= state_n;
      if (eng_rvalid_i)
        idx_r <= last_lane ? '0 : idx_r + 1'b1; // Back to lane 0 after each vector.
    end
  end

  // Operands and pointers.
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      a_ptr_r   <= a_ptr_i;
      b_ptr_r   <= b_ptr_i;
      res_ptr_r <= res_ptr_i;
      len_r     <= len_i;
      for (int i = 0; i < max_len; i++) begin
        vec_a[i] <= '0; // Unused lanes add zero.
        vec_b[i] <= '0;
      end
    end else if (eng_rvalid_i && state_r == e_wait_a) begin
      vec_a[idx_r] <= rdata_i;
    end else if (eng_rvalid_i && state_r == e_wait_b) begin
      vec_b[idx_r] <= rdata_i;
    end
  end

  for (genvar i = 0; i < max_len; i++) begin : g_mul
    assign prod[i] = vec_a[i] * vec_b[i]; // Low 64 bits kept.
  end

  for (genvar i = 0; i < max_len/2; i++) begin : g_sum_l1
    assign sum_l1[i] = prod[2*i] + prod[2*i+1];
  end

  for (genvar i = 0; i < max_len/4; i++) begin : g_sum_l2
    assign sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
  end

  assign eng_wdata_o = sum_l2[0] + sum_l2[1];

  always_comb begin
    case (state_r)
      e_fetch_b: eng_addr_o = spm_addr_t'(b_ptr_r + idx_r);
      e_write:   eng_addr_o = res_ptr_r;
      default:   eng_addr_o = spm_addr_t'(a_ptr_r + idx_r);
    endcase
  end

  assign eng_req_o = (state_r == e_fetch_a) || (state_r == e_fetch_b) || (state_r == e_write);
  assign eng_we_o  = (state_r == e_write);
  assign busy_o    = (state_r != e_idle);
  assign done_o    = (state_r == e_done);

  a_len_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    start_i |-> (len_i >= vec_len_t'(1)) && (len_i <= vec_len_t'(max_len)));

  // Read data only comes back for a read this engine was granted.
  a_rvalid_in_wait: assert property (@(posedge clk_i) disable iff (reset_i)
    eng_rvalid_i |-> (state_r == e_wait_a) || (state_r == e_wait_b));

endmodule

/* hw/spm_arbiter.sv */
`timescale 1ns/10ps

module spm_arbiter (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               host_req_i,
  input  logic               host_we_i,
  input  vdp_pkg::spm_addr_t host_addr_i,
  input  vdp_pkg::data_t     host_wdata_i,
  input  logic               eng_req_i,
  input  logic               eng_we_i,
  input  vdp_pkg::spm_addr_t eng_addr_i,
  input  vdp_pkg::data_t     eng_wdata_i,
  output logic               eng_gnt_o,
  output logic               mem_v_o,
  output logic               mem_we_o,
  output vdp_pkg::spm_addr_t mem_addr_o,
  output vdp_pkg::data_t     mem_wdata_o,
  input  vdp_pkg::data_t     mem_rdata_i,
  output vdp_pkg::data_t     rdata_o,
  output logic               host_rvalid_o,
  output logic               eng_rvalid_o
);

  assign eng_gnt_o   = eng_req_i && !host_req_i; // Host always wins.
  assign mem_v_o     = host_req_i || eng_req_i;
  assign mem_we_o    = host_req_i ? host_we_i : eng_we_i;
  assign mem_addr_o  = host_req_i ? host_addr_i : eng_addr_i;
  assign mem_wdata_o = host_req_i ? host_wdata_i : eng_wdata_i;

  // Owner of the read issued last cycle.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      host_rvalid_o <= 1'b0;
      eng_rvalid_o  <= 1'b0;
    end else begin
      host_rvalid_o <= host_req_i && !host_we_i;
      eng_rvalid_o  <= eng_gnt_o && !eng_we_i;
    end
  end

  assign rdata_o = mem_rdata_i;

  // A stalled engine request stays put until granted.
  a_eng_holds: assert property (@(posedge clk_i) disable iff (reset_i)
    (eng_req_i && !eng_gnt_o) |=> eng_req_i && $stable(eng_we_i) &&
                                  $stable(eng_addr_i) && $stable(eng_wdata_i));

endmodule

/* hw/spm_ram.sv */
`timescale 1ns/10ps

module spm_ram (
  input  logic               clk_i,
  input  logic               v_i,
  input  logic               we_i,
  input  vdp_pkg::spm_addr_t addr_i,
  input  vdp_pkg::data_t     wdata_i,
  output vdp_pkg::data_t     rdata_o
);
  import vdp_pkg::*;

  data_t mem [spm_words];

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (we_i)
        mem[addr_i] <= wdata_i;
      else
        rdata_o <= mem[addr_i]; // Valid the cycle after v_i.
    end
  end

  a_addr_known: assert property (@(posedge clk_i) v_i |-> !$isunknown(addr_i));

endmodule

/* hw/vdp_accel_top.sv */
`timescale 1ns/10ps

module vdp_accel_top (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               cmd_v_i,
  input  logic               cmd_we_i,
  input  logic               cmd_spm_i,
  input  vdp_pkg::spm_addr_t cmd_addr_i,
  input  vdp_pkg::data_t     cmd_wdata_i,
  output logic               resp_v_o,
  output vdp_pkg::data_t     resp_rdata_o
);
  import vdp_pkg::*;

  logic      host_req, host_we, host_rvalid;
  spm_addr_t host_addr;
  data_t     host_wdata;
  logic      eng_req, eng_we, eng_gnt, eng_rvalid;
  spm_addr_t eng_addr;
  data_t     eng_wdata;
  logic      mem_v, mem_we;
  spm_addr_t mem_addr;
  data_t     mem_wdata, mem_rdata, rdata;
  logic      start, busy, done;
  spm_addr_t a_ptr, b_ptr, res_ptr;
  vec_len_t  len;

  vdp_csr_file csr (
    .clk_i, .reset_i,
    .cmd_v_i, .cmd_we_i, .cmd_spm_i, .cmd_addr_i, .cmd_wdata_i,
    .resp_v_o, .resp_rdata_o,
    .host_req_o(host_req), .host_we_o(host_we), .host_addr_o(host_addr),
    .host_wdata_o(host_wdata), .host_rvalid_i(host_rvalid), .rdata_i(rdata),
    .start_o(start), .a_ptr_o(a_ptr), .b_ptr_o(b_ptr), .res_ptr_o(res_ptr),
    .len_o(len), .busy_i(busy), .done_i(done)
  );

  vdp_engine engine (
    .clk_i, .reset_i,
    .start_i(start), .a_ptr_i(a_ptr), .b_ptr_i(b_ptr), .res_ptr_i(res_ptr),
    .len_i(len), .busy_o(busy), .done_o(done),
    .eng_req_o(eng_req), .eng_we_o(eng_we), .eng_addr_o(eng_addr),
    .eng_wdata_o(eng_wdata), .eng_gnt_i(eng_gnt), .eng_rvalid_i(eng_rvalid),
    .rdata_i(rdata)
  );

  spm_arbiter arb (
    .clk_i, .reset_i,
    .host_req_i(host_req), .host_we_i(host_we), .host_addr_i(host_addr),
    .host_wdata_i(host_wdata),
    .eng_req_i(eng_req), .eng_we_i(eng_we), .eng_addr_i(eng_addr),
    .eng_wdata_i(eng_wdata), .eng_gnt_o(eng_gnt),
    .mem_v_o(mem_v), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata),
    .rdata_o(rdata), .host_rvalid_o(host_rvalid), .eng_rvalid_o(eng_rvalid)
  );

  spm_ram spm (
    .clk_i,
    .v_i(mem_v), .we_i(mem_we), .addr_i(mem_addr),
    .wdata_i(mem_wdata), .rdata_o(mem_rdata)
  );

endmodule

/* test/tb_vdp_accel.sv */
`timescale 1ns/10ps

module tb_vdp_accel;
  import vdp_pkg::*;

  localparam int num_runs       = 20;
  localparam int cycles_per_run = 200;
  localparam int timeout_cycles = num_runs * cycles_per_run + 2000;
  localparam int resp_limit     = 16;
  localparam int poll_limit     = 200;

  logic      clk;
  logic      reset;
  logic      cmd_v;
  logic      cmd_we;
  logic      cmd_spm;
  spm_addr_t cmd_addr;
  data_t     cmd_wdata;
  logic      resp_v;
  data_t     resp_rdata;

  data_t       spm_model [spm_words];
  logic [31:0] lcg_state;
  int          cycle_cnt = 0;

  vdp_accel_top UUT (
    .clk_i(clk), .reset_i(reset),
    .cmd_v_i(cmd_v), .cmd_we_i(cmd_we), .cmd_spm_i(cmd_spm),
    .cmd_addr_i(cmd_addr), .cmd_wdata_i(cmd_wdata),
    .resp_v_o(resp_v), .resp_rdata_o(resp_rdata)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic data_t rand_word();
    data_t w;
    w[63:32] = next_rand();
    w[31:0]  = next_rand();
    return w;
  endfunction

  // Length register saturates into 1..max_len.
  function automatic data_t clamp_len(input data_t v);
    if (v == '0)
      return 64'd1;
    else if (v > 64'(max_len))
      return 64'(max_len);
    else
      return v;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s: expected %h, got %h", $time, name, exp, act);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles)
      abort_run("Simulation ran past its cycle limit without finishing.");
  end

  // One command, then count cycles until the response pulse.
  task automatic send_cmd(input logic we, input logic spm, input spm_addr_t addr,
                          input data_t wdata, output data_t rdata, output int lat);
    @(posedge clk);
    #1;
    cmd_v     = 1'b1;
    cmd_we    = we;
    cmd_spm   = spm;
    cmd_addr  = addr;
    cmd_wdata = wdata;
    @(posedge clk);
    #1;
    cmd_v = 1'b0;
    lat   = 1;
    while (!resp_v && lat < resp_limit) begin
      @(posedge clk);
      #1;
      lat++;
    end
    if (!resp_v)
      abort_run("Host command got no response.");
    else
      rdata = resp_rdata;
  endtask

  task automatic host_write(input logic spm, input spm_addr_t addr, input data_t wdata);
    data_t rdata;
    int    lat;
    send_cmd(1'b1, spm, addr, wdata, rdata, lat);
    check_value("write resp latency", 1, lat);
    check_value("write resp_rdata", '0, rdata);
  endtask

  task automatic host_read(input logic spm, input spm_addr_t addr, output data_t rdata);
    int lat;
    send_cmd(1'b0, spm, addr, '0, rdata, lat);
    check_value("read resp latency", spm ? 2 : 1, lat);
  endtask

  task automatic write_read_reg(input logic [2:0] idx, input data_t wdata,
                                input data_t exp, input string name);
    data_t value;
    host_write(1'b0, spm_addr_t'(idx), wdata);
    host_read(1'b0, spm_addr_t'(idx), value);
    check_value(name, exp, value);
  endtask

  task automatic check_registers();
    data_t value;
    data_t wdata;
    data_t len_vals [6];
    len_vals = '{64'd0, 64'd1, 64'd5, 64'd8, 64'd9, 64'hffff_ffff_ffff_fff3};
    host_read(1'b0, spm_addr_t'(reg_status), value);
    check_value("status after reset", '0, value);
    repeat (8) begin
      wdata = rand_word();
      write_read_reg(reg_a_ptr, wdata, wdata & 64'h1f, "a_ptr");
      wdata = rand_word();
      write_read_reg(reg_b_ptr, wdata, wdata & 64'h1f, "b_ptr");
      wdata = rand_word();
      write_read_reg(reg_res_ptr, wdata, wdata & 64'h1f, "res_ptr");
    end
    for (int n = 0; n < 6; n++)
      write_read_reg(reg_len, len_vals[n], clamp_len(len_vals[n]), "len");
    repeat (4) begin
      wdata = 64'(next_rand() % 12);
      write_read_reg(reg_len, wdata, clamp_len(wdata), "len");
    end
    write_read_reg(3'd6, rand_word(), '0, "reg 6");
    write_read_reg(3'd7, rand_word(), '0, "reg 7");
  endtask

  task automatic check_scratchpad();
    data_t     value;
    spm_addr_t addr;
    for (int i = 0; i < spm_words; i++) begin
      spm_model[i] = rand_word();
      host_write(1'b1, spm_addr_t'(i), spm_model[i]);
    end
    repeat (24) begin
      addr = spm_addr_t'(next_rand());
      spm_model[addr] = rand_word();
      host_write(1'b1, addr, spm_model[addr]);
    end
    for (int i = 0; i < spm_words; i++) begin
      host_read(1'b1, spm_addr_t'(i), value);
      check_value($sformatf("spm[%0d]", i), spm_model[i], value);
    end
  endtask

  // Four 8-word blocks hold A, B, the result word and free host traffic.
  task automatic run_dot(input int run);
    int        blk;
    int        len;
    int        a_base;
    int        b_base;
    int        f_base;
    int        polls;
    spm_addr_t res_addr;
    spm_addr_t free_addr;
    data_t     expected;
    data_t     status;
    data_t     value;
    blk      = next_rand() % 4;
    len      = next_rand() % max_len + 1;
    a_base   = blk * 8;
    b_base   = ((blk + 1) % 4) * 8;
    res_addr = spm_addr_t'(((blk + 2) % 4) * 8 + next_rand() % 8);
    f_base   = ((blk + 3) % 4) * 8;
    expected = '0;
    for (int i = 0; i < len; i++) begin
      spm_model[a_base+i] = rand_word();
      spm_model[b_base+i] = rand_word();
      host_write(1'b1, spm_addr_t'(a_base + i), spm_model[a_base+i]);
      host_write(1'b1, spm_addr_t'(b_base + i), spm_model[b_base+i]);
      expected = expected + spm_model[a_base+i] * spm_model[b_base+i]; // Modulo 2^64.
    end
    host_write(1'b0, spm_addr_t'(reg_a_ptr), data_t'(a_base));
    host_write(1'b0, spm_addr_t'(reg_b_ptr), data_t'(b_base));
    host_write(1'b0, spm_addr_t'(reg_res_ptr), data_t'(res_addr));
    host_write(1'b0, spm_addr_t'(reg_len), data_t'(len));
    host_write(1'b0, spm_addr_t'(reg_start), data_t'(next_rand()) | 64'd1);
    host_read(1'b0, spm_addr_t'(reg_status), status);
    check_value("status busy on first poll", 1, status[status_busy_bit]);
    check_value("status done on first poll", 0, status[status_done_bit]);
    if (run % 2 == 1) begin
      host_write(1'b0, spm_addr_t'(reg_a_ptr), data_t'(b_base)); // A restart would do B times B.
      host_write(1'b0, spm_addr_t'(reg_start), 64'd1); // Must be ignored while busy.
    end
    polls = 0;
    while (!status[status_done_bit] && polls < poll_limit) begin
      if (next_rand() % 2 == 1) begin
        free_addr = spm_addr_t'(f_base + next_rand() % 8);
        spm_model[free_addr] = rand_word();
        host_write(1'b1, free_addr, spm_model[free_addr]);
        host_read(1'b1, free_addr, value);
        check_value("spm word during run", spm_model[free_addr], value);
      end
      host_read(1'b0, spm_addr_t'(reg_status), status);
      polls++;
    end
    if (!status[status_done_bit]) begin
      abort_run("Engine never set the done bit in status.");
    end else begin
      check_value("status busy at done", 0, status[status_busy_bit]);
      host_read(1'b1, res_addr, value);
      check_value($sformatf("dot product run %0d", run), expected, value);
      spm_model[res_addr] = expected;
    end
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    cmd_v     = 1'b0;
    cmd_we    = 1'b0;
    cmd_spm   = 1'b0;
    cmd_addr  = '0;
    cmd_wdata = '0;
    lcg_state = 32'hf8cb8472;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    check_registers();
    check_scratchpad();
    for (int r = 0; r < num_runs; r++)
      run_dot(r);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* sources.f */
hw/vdp_pkg.sv
hw/vdp_csr_file.sv
hw/vdp_engine.sv
hw/spm_arbiter.sv
hw/spm_ram.sv
hw/vdp_accel_top.sv
test/tb_vdp_accel.sv
